//--- common/rs_dec_pkg.sv
//--------------------------------------------------------------------------
// RS(15,13) code constants and GF(16) arithmetic for the interleaved decoder
// field polynomial x^4+x+1, generator roots alpha^1 and alpha^2
// gf_log of a zero symbol returns 0, so callers must classify zero first
//--------------------------------------------------------------------------

package rs_dec_pkg;

  // code geometry
  localparam int cM      = 4;
  localparam int cN      = 15;
  localparam int cCHECK  = 2;
  localparam int cLANES  = 4;
  localparam int cWORD_W = cLANES * cM;

  // x^4 + x + 1
  localparam logic [cM:0] cIRRPOL = 5'b10011;

  typedef logic [cM-1:0]      sym_t;
  typedef logic [cWORD_W-1:0] word_t;
  typedef logic               ptr_t;
  typedef logic [3:0]         addr_t;

  // per-lane and summed statistics
  typedef logic       symerr_t;
  typedef logic [2:0] biterr_t;
  typedef logic [2:0] decerr_t;
  typedef logic [2:0] sumsym_t;
  typedef logic [4:0] sumbit_t;

  // shift-and-add multiply, reduced each step
  function automatic sym_t gf_mul(input sym_t a, input sym_t b);
    sym_t          r;
    logic [cM:0]   t;
    r = '0;
    t = {1'b0, a};
    for (int i = 0; i < cM; i++) begin
      if (b[i]) begin
        r = r ^ t[cM-1:0];
      end
      t = {t[cM-1:0], 1'b0};
      if (t[cM]) begin
        t = t ^ cIRRPOL;
      end
    end
    return r;
  endfunction

  // alpha^e, e in 0..14
  function automatic sym_t gf_alog(input logic [cM-1:0] e);
    sym_t r;
    r = sym_t'(1);
    for (int i = 0; i < cN; i++) begin
      if (i < int'(e)) begin
        r = gf_mul(r, sym_t'(2));
      end
    end
    return r;
  endfunction

  // search over all powers of alpha
  function automatic logic [cM-1:0] gf_log(input sym_t a);
    logic [cM-1:0] r;
    sym_t          p;
    r = '0;
    p = sym_t'(1);
    for (int i = 0; i < cN; i++) begin
      if (p == a) begin
        r = (cM)'(i);
      end
      p = gf_mul(p, sym_t'(2));
    end
    return r;
  endfunction

endpackage

//--- syndrome/rs_syndrome_lane.sv
//--------------------------------------------------------------------------
// syndrome pair for one lane, Horner evaluation at alpha and alpha^2
// first accepted symbol is the highest degree term
// ival must already be qualified by the framer, ieop only on a valid word
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module rs_syndrome_lane
  import rs_dec_pkg::*;
(
  input  logic iclk,
  input  logic rst,
  input  logic iclkena,
  input  logic ival,
  input  logic isop,
  input  logic ieop,
  input  sym_t idat,
  output logic syn_val,
  output sym_t s1,
  output sym_t s2
);

  sym_t acc1;
  sym_t acc2;
  sym_t nxt1;
  sym_t nxt2;

  // isop drops the old accumulator instead of scaling it
  always_comb begin
    nxt1 = (isop ? sym_t'(0) : gf_mul(acc1, gf_alog(4'd1))) ^ idat;
    nxt2 = (isop ? sym_t'(0) : gf_mul(acc2, gf_alog(4'd2))) ^ idat;
  end

  // strobe
  always_ff @(posedge iclk) begin
    if (rst) begin
      syn_val <= 1'b0;
    end else if (iclkena) begin
      syn_val <= ival & ieop;
    end
  end

  // accumulators and final pair
  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      acc1 <= nxt1;
      acc2 <= nxt2;
      if (ieop) begin
        // parity word folded in, pair is final
        s1 <= nxt1;
        s2 <= nxt2;
      end
    end
  end

endmodule

//--- verilog/rs_frame_buffer.sv
//--------------------------------------------------------------------------
// two-page frame store, 16 words per page, 15 used
// read data is registered and valid one enabled cycle after read
// no collision handling, same page and index read and written gives old data
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module rs_frame_buffer
  import rs_dec_pkg::*;
(
  input  logic  iclk,
  input  logic  iclkena,
  input  logic  write,
  input  ptr_t  wptr,
  input  addr_t waddr,
  input  word_t wdata,
  input  logic  read,
  input  ptr_t  rptr,
  input  addr_t raddr,
  output word_t rdata
);

  localparam int cDEPTH = 2 ** ($bits(ptr_t) + $bits(addr_t));

  word_t mem [cDEPTH];

  // page select is the address msb
  logic [$bits(ptr_t)+$bits(addr_t)-1:0] wa;
  logic [$bits(ptr_t)+$bits(addr_t)-1:0] ra;

  assign wa = {wptr, waddr};
  assign ra = {rptr, raddr};

  // write port
  always_ff @(posedge iclk) begin
    if (iclkena && write) begin
      mem[wa] <= wdata;
    end
  end

  // registered read port
  always_ff @(posedge iclk) begin
    if (iclkena && read) begin
      rdata <= mem[ra];
    end
  end

endmodule

//--- locator/rs_error_locator.sv
//--------------------------------------------------------------------------
// single-symbol error solver for one lane, two register stages
// s1 = e*X, s2 = e*X^2 so X = s2/s1 and e = s1^2/s2
// two or more errors may alias to a wrong single position (miscorrection)
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module rs_error_locator
  import rs_dec_pkg::*;
(
  input  logic  iclk,
  input  logic  rst,
  input  logic  iclkena,
  input  logic  syn_val,
  input  sym_t  s1,
  input  sym_t  s2,
  output logic  loc_val,
  output addr_t err_pos,
  output sym_t  err_val,
  output logic  decfail
);

  // stage one state
  logic          v1;
  logic [cM-1:0] l1;
  logic [cM-1:0] l2;
  logic          clean1;
  logic          fail1;

  // degree and error value log
  logic [cM-1:0] deg;
  logic [cM-1:0] elog;

  // reduce 0..44 into 0..14
  function automatic logic [cM-1:0] mod15(input logic [5:0] v);
    logic [5:0] r;
    r = v;
    if (r >= 6'd30) begin
      r = r - 6'd30;
    end else if (r >= 6'd15) begin
      r = r - 6'd15;
    end
    return r[cM-1:0];
  endfunction

  assign deg  = mod15({2'b00, l2} + 6'd15 - {2'b00, l1});
  assign elog = mod15({1'b0, l1, 1'b0} + 6'd15 - {2'b00, l2});

  // strobes
  always_ff @(posedge iclk) begin
    if (rst) begin
      v1      <= 1'b0;
      loc_val <= 1'b0;
    end else if (iclkena) begin
      v1      <= syn_val;
      loc_val <= v1;
    end
  end

  // stage one, logs and classification
  always_ff @(posedge iclk) begin
    if (iclkena && syn_val) begin
      l1     <= gf_log(s1);
      l2     <= gf_log(s2);
      clean1 <= (s1 == '0) && (s2 == '0);
      fail1  <= (s1 == '0) != (s2 == '0);
    end
  end

  // stage two, word index counts from the high degree end
  always_ff @(posedge iclk) begin
    if (iclkena && v1) begin
      decfail <= fail1;
      err_pos <= (clean1 | fail1) ? addr_t'(0) : addr_t'(cN - 1) - addr_t'(deg);
      err_val <= (clean1 | fail1) ? sym_t'(0) : gf_alog(elog);
    end
  end

endmodule

//--- correct/rs_corrector.sv
//--------------------------------------------------------------------------
// per-lane read sequencer and symbol fix-up
// rd_en/rd_addr are combinational so the first read goes out with loc_val
// a loc_val during a running frame restarts the sequence
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module rs_corrector
  import rs_dec_pkg::*;
(
  input  logic    iclk,
  input  logic    rst,
  input  logic    iclkena,
  input  logic    loc_val,
  input  addr_t   err_pos,
  input  sym_t    err_val,
  input  logic    decfail,
  input  sym_t    rd_data,
  output logic    rd_en,
  output addr_t   rd_addr,
  output logic    oval,
  output logic    osop,
  output logic    oeof,
  output sym_t    odat,
  output logic    odecfail,
  output symerr_t num_err_sym,
  output biterr_t num_err_bit
);

  localparam addr_t cLAST = addr_t'(cN - 1);

  logic  busy;
  addr_t cnt;
  logic  rd_val;
  addr_t rd_idx;

  // latched locator result
  addr_t pos_q;
  sym_t  val_q;
  logic  fail_q;

  logic  hit;

  assign rd_en   = loc_val | busy;
  assign rd_addr = loc_val ? addr_t'(0) : cnt;
  assign hit     = (rd_idx == pos_q) & ~fail_q;

  // sequencer and output strobes
  always_ff @(posedge iclk) begin
    if (rst) begin
      busy   <= 1'b0;
      cnt    <= '0;
      rd_val <= 1'b0;
      oval   <= 1'b0;
      osop   <= 1'b0;
      oeof   <= 1'b0;
    end else if (iclkena) begin
      if (loc_val) begin
        busy <= 1'b1;
        cnt  <= addr_t'(1);
      end else if (busy) begin
        busy <= (cnt != cLAST);
        cnt  <= cnt + 1'b1;
      end
      rd_val <= rd_en;
      oval   <= rd_val;
      osop   <= rd_val & (rd_idx == '0);
      oeof   <= rd_val & (rd_idx == cLAST);
    end
  end

  // payload path
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      rd_idx <= rd_addr;
      if (loc_val) begin
        pos_q  <= err_pos;
        val_q  <= err_val;
        fail_q <= decfail;
      end
      odat <= rd_data ^ (hit ? val_q : sym_t'(0));
      // stats go out with the last word, before a new result is latched
      if (rd_val && (rd_idx == cLAST)) begin
        odecfail    <= fail_q;
        num_err_sym <= (val_q != '0) & ~fail_q;
        num_err_bit <= fail_q ? biterr_t'(0) : biterr_t'($countones(val_q));
      end
    end
  end

endmodule

//--- verilog/rs_il_dec.sv
//--------------------------------------------------------------------------
// 4-lane interleaved RS(15,13) decoder, one correctable symbol per lane
// no back-pressure, frames must end at least 15 enabled cycles apart
// failed lanes pass through uncorrected, odecerr counts them
// words before the first isop are dropped
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module rs_il_dec
  import rs_dec_pkg::*;
(
  input  logic    iclk,
  input  logic    rst,
  input  logic    iclkena,
  input  logic    ival,
  input  logic    isop,
  input  word_t   idat,
  output logic    oval,
  output logic    osop,
  output word_t   odat,
  output logic    odecval,
  output decerr_t odecerr,
  output sumsym_t osymerr,
  output sumbit_t obiterr
);

  //--------------------------------------------------------------------------
  // input framer
  //--------------------------------------------------------------------------

  addr_t cnt;
  logic  in_frame;
  addr_t widx;
  logic  wr_en;
  logic  eop;
  ptr_t  wptr;
  ptr_t  rptr_q;
  ptr_t  rptr;

  assign widx  = isop ? addr_t'(0) : cnt;
  assign wr_en = iclkena & ival & (isop | in_frame);
  assign eop   = wr_en & (widx == addr_t'(cN - 1));

  always_ff @(posedge iclk) begin
    if (rst) begin
      cnt      <= '0;
      in_frame <= 1'b0;
      wptr     <= 1'b0;
    end else if (wr_en) begin
      cnt      <= widx + 1'b1;
      in_frame <= ~eop;
      // next frame fills the other page
      if (eop) begin
        wptr <= ~wptr;
      end
    end
  end

  //--------------------------------------------------------------------------
  // lanes
  //--------------------------------------------------------------------------

  logic    syn_val [cLANES];
  sym_t    s1      [cLANES];
  sym_t    s2      [cLANES];
  logic    loc_val [cLANES];
  addr_t   err_pos [cLANES];
  sym_t    err_val [cLANES];
  logic    decfail [cLANES];
  logic    rd_en   [cLANES];
  addr_t   rd_addr [cLANES];
  logic    l_oval  [cLANES];
  logic    l_osop  [cLANES];
  logic    l_oeof  [cLANES];
  sym_t    l_odat  [cLANES];
  logic    l_fail  [cLANES];
  symerr_t l_sym   [cLANES];
  biterr_t l_bit   [cLANES];
  word_t   rdata;

  for (genvar g = 0; g < cLANES; g++) begin : lane_gen
    rs_syndrome_lane u_syn (
      .iclk(iclk), .rst(rst), .iclkena(iclkena),
      .ival(wr_en), .isop(isop), .ieop(eop), .idat(idat[g*cM +: cM]),
      .syn_val(syn_val[g]), .s1(s1[g]), .s2(s2[g])
    );

    // lane 0 strobes drive every lane
    rs_error_locator u_loc (
      .iclk(iclk), .rst(rst), .iclkena(iclkena),
      .syn_val(syn_val[0]), .s1(s1[g]), .s2(s2[g]),
      .loc_val(loc_val[g]), .err_pos(err_pos[g]), .err_val(err_val[g]),
      .decfail(decfail[g])
    );

    rs_corrector u_cor (
      .iclk(iclk), .rst(rst), .iclkena(iclkena),
      .loc_val(loc_val[0]), .err_pos(err_pos[g]), .err_val(err_val[g]),
      .decfail(decfail[g]), .rd_data(rdata[g*cM +: cM]),
      .rd_en(rd_en[g]), .rd_addr(rd_addr[g]),
      .oval(l_oval[g]), .osop(l_osop[g]), .oeof(l_oeof[g]), .odat(l_odat[g]),
      .odecfail(l_fail[g]), .num_err_sym(l_sym[g]), .num_err_bit(l_bit[g])
    );

    assign odat[g*cM +: cM] = l_odat[g];
  end

  //--------------------------------------------------------------------------
  // frame buffer, read page follows the frame into the corrector
  //--------------------------------------------------------------------------

  // wptr has already toggled, so ~wptr is the page just filled
  assign rptr = loc_val[0] ? ~wptr : rptr_q;

  always_ff @(posedge iclk) begin
    if (rst) begin
      rptr_q <= 1'b0;
    end else if (iclkena && loc_val[0]) begin
      rptr_q <= ~wptr;
    end
  end

  rs_frame_buffer u_buf (
    .iclk(iclk), .iclkena(iclkena),
    .write(wr_en), .wptr(wptr), .waddr(widx), .wdata(idat),
    .read(rd_en[0]), .rptr(rptr), .raddr(rd_addr[0]), .rdata(rdata)
  );

  assign oval = l_oval[0];
  assign osop = l_osop[0];

  //--------------------------------------------------------------------------
  // error statistics
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (rst) begin
      odecval <= 1'b0;
    end else if (iclkena) begin
      odecval <= l_oeof[0];
    end
  end

  always_ff @(posedge iclk) begin
    decerr_t de;
    sumsym_t se;
    sumbit_t be;
    de = '0;
    se = '0;
    be = '0;
    for (int i = 0; i < cLANES; i++) begin
      de = de + decerr_t'(l_fail[i]);
      se = se + sumsym_t'(l_sym[i]);
      be = be + sumbit_t'(l_bit[i]);
    end
    // held until the next frame ends
    if (iclkena && l_oeof[0]) begin
      odecerr <= de;
      osymerr <= se;
      obiterr <= be;
    end
  end

endmodule

//--- sim/rs_il_dec_asserts.sv
//--------------------------------------------------------------------------
// strobe checks on the decoder top level, bound into every rs_il_dec
// odecval holds while iclkena is low, so its length counts enabled cycles
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module rs_il_dec_asserts (
  input logic iclk,
  input logic rst,
  input logic iclkena,
  input logic oval,
  input logic osop,
  input logic odecval
);

  // start of frame only on a valid word
  a_sop_has_val: assert property (@(posedge iclk) disable iff (rst) osop |-> oval)
    else $error("osop high without oval");

  // stats strobe lasts one enabled cycle
  a_decval_pulse: assert property (
    @(posedge iclk) disable iff (rst) (odecval && iclkena) |=> !odecval
  ) else $error("odecval high for more than one enabled cycle");

  // output idle right after reset
  a_idle_after_rst: assert property (@(posedge iclk) rst |=> !oval)
    else $error("oval high in the cycle after reset");

endmodule

bind rs_il_dec rs_il_dec_asserts u_asserts (.*);

//--- sim/rs_il_dec_tb.sv
//--------------------------------------------------------------------------
// testbench for the 4-lane interleaved RS(15,13) decoder
// encoder and single-error decode rule are modelled here in GF(16)
// outputs are sampled on the falling edge after an enabled rising edge
// frames go in at one word per enabled cycle at most
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module rs_il_dec_tb
  import rs_dec_pkg::*;
();

  logic    iclk = 1'b0;
  logic    rst;
  logic    iclkena;
  logic    ival;
  logic    isop;
  word_t   idat;
  logic    oval;
  logic    osop;
  word_t   odat;
  logic    odecval;
  decerr_t odecerr;
  sumsym_t osymerr;
  sumbit_t obiterr;

  integer seed;
  int     errors = 0;
  int     checks = 0;
  int     tests = 0;
  int     bad_tests = 0;

  // enable and reset as seen by the last rising edge
  logic en_q = 1'b0;
  logic rst_q = 1'b1;

  // GF(16) tables, alpha = x
  sym_t alog_t [15];
  int   log_t  [16];

  // sent codeword, received word and expected decoder output
  word_t tx  [15];
  word_t rx  [15];
  word_t dec [15];
  int    inj_sym;
  int    inj_bit;

  // expected words, sop flags and {decerr, symerr, biterr}
  word_t       exp_q  [$];
  logic        sop_q  [$];
  logic [10:0] stat_q [$];

  rs_il_dec u_dut (
    .iclk(iclk), .rst(rst), .iclkena(iclkena),
    .ival(ival), .isop(isop), .idat(idat),
    .oval(oval), .osop(osop), .odat(odat),
    .odecval(odecval), .odecerr(odecerr), .osymerr(osymerr), .obiterr(obiterr)
  );

  always #5 iclk = ~iclk;

  always @(posedge iclk) begin
    en_q  <= iclkena;
    rst_q <= rst;
  end

  //--------------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------------

  task automatic note_fail(input string msg);
    errors++;
    $display("FAIL %0t ns: %s", $time, msg);
  endtask

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic build_tables();
    sym_t p;
    p = sym_t'(1);
    for (int i = 0; i < 15; i++) begin
      alog_t[i] = p;
      log_t[p]  = i;
      // times x, x^4 folds back to x+1
      p = {p[2:0], 1'b0} ^ (p[3] ? sym_t'(3) : sym_t'(0));
    end
    log_t[0] = 0;
  endtask

  function automatic sym_t fmul(input sym_t a, input sym_t b);
    if (a == '0 || b == '0) begin
      return '0;
    end
    return alog_t[(log_t[a] + log_t[b]) % 15];
  endfunction

  // random message, parity per lane as remainder mod g(x) = (x+a)(x+a^2)
  task automatic build_frame();
    sym_t g1;
    sym_t g0;
    sym_t r1;
    sym_t r0;
    sym_t fb;
    g1 = alog_t[1] ^ alog_t[2];
    g0 = fmul(alog_t[1], alog_t[2]);
    for (int i = 0; i < cN - cCHECK; i++) begin
      tx[i] = word_t'($random(seed));
    end
    for (int l = 0; l < cLANES; l++) begin
      r1 = '0;
      r0 = '0;
      for (int i = 0; i < cN - cCHECK; i++) begin
        fb = tx[i][l*cM +: cM] ^ r1;
        r1 = r0 ^ fmul(fb, g1);
        r0 = fmul(fb, g0);
      end
      tx[cN-2][l*cM +: cM] = r1;
      tx[cN-1][l*cM +: cM] = r0;
    end
  endtask

  // up to max_err nonzero symbol errors per lane, positions may repeat
  task automatic corrupt(input int max_err);
    int   n;
    int   pos;
    sym_t e;
    inj_sym = 0;
    inj_bit = 0;
    for (int i = 0; i < cN; i++) begin
      rx[i] = tx[i];
    end
    for (int l = 0; l < cLANES; l++) begin
      n = rand_below(max_err + 1);
      if (n > 0) begin
        inj_sym++;
      end
      for (int k = 0; k < n; k++) begin
        pos = rand_below(cN);
        e   = sym_t'(rand_below(15) + 1);
        rx[pos][l*cM +: cM] = rx[pos][l*cM +: cM] ^ e;
        inj_bit += $countones(e);
      end
    end
  endtask

  // without the model the sent codeword and injected counts are expected
  task automatic expect_frame(input bit use_model);
    sym_t s1;
    sym_t s2;
    sym_t v;
    int   deg;
    int   nd;
    int   ns;
    int   nb;
    nd = 0;
    ns = inj_sym;
    nb = inj_bit;
    for (int i = 0; i < cN; i++) begin
      dec[i] = use_model ? rx[i] : tx[i];
    end
    if (use_model) begin
      ns = 0;
      nb = 0;
      for (int l = 0; l < cLANES; l++) begin
        s1 = '0;
        s2 = '0;
        for (int i = 0; i < cN; i++) begin
          s1 = fmul(s1, alog_t[1]) ^ rx[i][l*cM +: cM];
          s2 = fmul(s2, alog_t[2]) ^ rx[i][l*cM +: cM];
        end
        if ((s1 == '0) != (s2 == '0)) begin
          nd++;
        end else if (s1 != '0) begin
          // X = s2/s1, e = s1^2/s2
          deg = (log_t[s2] - log_t[s1] + 15) % 15;
          v   = alog_t[(2 * log_t[s1] - log_t[s2] + 15) % 15];
          dec[cN-1-deg][l*cM +: cM] = dec[cN-1-deg][l*cM +: cM] ^ v;
          ns++;
          nb += $countones(v);
        end
      end
    end
    for (int i = 0; i < cN; i++) begin
      exp_q.push_back(dec[i]);
      sop_q.push_back(i == 0);
    end
    stat_q.push_back({3'(nd), 3'(ns), 5'(nb)});
  endtask

  // idle slots either drop iclkena or leave ival low
  task automatic send_frame(input int nwords, input bit gaps);
    logic [31:0] r;
    int          idle;
    for (int i = 0; i < nwords; i++) begin
      idle = gaps ? rand_below(3) : 0;
      for (int k = 0; k < idle; k++) begin
        r       = $random(seed);
        iclkena = ~r[0];
        ival    = r[0];
        isop    = 1'b0;
        idat    = r[31:16];
        @(negedge iclk);
      end
      iclkena = 1'b1;
      ival    = 1'b1;
      isop    = (i == 0);
      idat    = rx[i];
      @(negedge iclk);
    end
  endtask

  task automatic drain();
    int n;
    iclkena = 1'b1;
    ival    = 1'b0;
    isop    = 1'b0;
    n       = 0;
    while ((exp_q.size() != 0 || stat_q.size() != 0) && n < 100) begin
      @(negedge iclk);
      n++;
    end
    if (exp_q.size() != 0 || stat_q.size() != 0) begin
      $display("timeout: decoder still owes %0d words and %0d status strobes",
               exp_q.size(), stat_q.size());
      $display("Some tests failed");
      $finish;
    end else begin
      repeat (3) @(negedge iclk);
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    if (errors != err_before) begin
      bad_tests++;
    end
    $display("test %-8s done: %0d errors", name, errors - err_before);
  endtask

  task automatic run_test(input string name, input int frames, input int max_err,
                          input bit use_model, input bit gaps);
    int e0;
    e0 = errors;
    for (int f = 0; f < frames; f++) begin
      build_frame();
      corrupt(max_err);
      expect_frame(use_model);
      // gapped frames alternate with back to back ones
      send_frame(cN, gaps && f[0]);
    end
    drain();
    finish_test(name, e0);
  endtask

  //--------------------------------------------------------------------------
  // output monitor
  //--------------------------------------------------------------------------

  always @(negedge iclk) begin
    word_t       w;
    logic        s;
    logic [10:0] st;
    if (rst_q) begin
      checks++;
      if (oval || osop || odecval) begin
        note_fail("output strobe high during reset");
      end
    end else if (en_q) begin
      if (oval) begin
        checks++;
        if (exp_q.size() == 0) begin
          note_fail("oval with no frame pending");
        end else begin
          w = exp_q.pop_front();
          s = sop_q.pop_front();
          if (odat !== w) begin
            note_fail($sformatf("odat %h, expected %h", odat, w));
          end
          if (osop !== s) begin
            note_fail($sformatf("osop %b, expected %b", osop, s));
          end
        end
      end
      if (odecval) begin
        checks++;
        if (stat_q.size() == 0) begin
          note_fail("odecval with no frame pending");
        end else begin
          st = stat_q.pop_front();
          if ({odecerr, osymerr, obiterr} !== st) begin
            note_fail($sformatf("dec/sym/bit %0d %0d %0d, expected %0d %0d %0d",
                      odecerr, osymerr, obiterr, st[10:8], st[7:5], st[4:0]));
          end
        end
      end
    end
  end

  //--------------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------------

  initial begin
    int e0;
    seed    = 32'h627c_f28f;
    rst     = 1'b1;
    iclkena = 1'b1;
    ival    = 1'b0;
    isop    = 1'b0;
    idat    = '0;
    build_tables();
    repeat (3) @(negedge iclk);
    rst = 1'b0;

    run_test("clean", 8, 0, 1'b0, 1'b0);
    run_test("single", 12, 1, 1'b0, 1'b0);
    run_test("double", 16, 2, 1'b1, 1'b0);
    run_test("gaps", 12, 1, 1'b1, 1'b1);

    // reset hits while one frame is coming out and the next is half in
    e0 = errors;
    build_frame();
    corrupt(1);
    expect_frame(1'b1);
    send_frame(cN, 1'b0);
    build_frame();
    corrupt(1);
    send_frame(7, 1'b0);
    rst     = 1'b1;
    iclkena = 1'b1;
    ival    = 1'b0;
    isop    = 1'b0;
    repeat (3) @(negedge iclk);
    rst = 1'b0;
    // rest of the cut frame never comes out
    exp_q.delete();
    sop_q.delete();
    stat_q.delete();
    repeat (2) @(negedge iclk);
    expect_frame(1'b1);
    send_frame(cN, 1'b0);
    drain();
    finish_test("reset", e0);

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests, bad_tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- compile.f
common/rs_dec_pkg.sv
syndrome/rs_syndrome_lane.sv
verilog/rs_frame_buffer.sv
locator/rs_error_locator.sv
correct/rs_corrector.sv
verilog/rs_il_dec.sv
sim/rs_il_dec_asserts.sv
sim/rs_il_dec_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := rs_il_dec_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
